// File: logic/lsu.sv
// Load/store unit
`default_nettype none

module lsu (
  input  logic              clk_i,
  input  logic              rst_i,
  // Core request
  input  lsu_pkg::tag_t     lsu_qtag_i,
  input  logic              lsu_qwrite_i,
  input  logic              lsu_qsigned_i,
  input  logic [31:0]       lsu_qaddr_i,
  input  logic [31:0]       lsu_qdata_i,
  input  lsu_pkg::size_e    lsu_qsize_i,
  input  lsu_pkg::amo_e     lsu_qamo_i,
  input  logic              lsu_qvalid_i,
  output logic              lsu_qready_o,
  // Core response
  output logic [31:0]       lsu_pdata_o,
  output lsu_pkg::tag_t     lsu_ptag_o,
  output logic              lsu_perror_o,
  output logic              lsu_pvalid_o,
  input  logic              lsu_pready_i,
  // Memory side
  mem_bus_if.lsu_mp         mem
);
  import lsu_pkg::*;
  import mem_pkg::*;

  lsu_meta_t   req_meta;
  lsu_meta_t   rsp_meta;
  id_t         req_id;
  logic        table_full;
  logic        is_store;
  logic        req_fire;
  logic        rsp_fire;
  logic [1:0]  offset;
  logic [31:0] shifted;

  assign offset = lsu_qaddr_i[1:0];

  // An AMO returns the old word, so only a plain store is a write
  assign is_store = lsu_qwrite_i && (lsu_qamo_i == AMO_NONE);

  assign req_meta = '{
    write:    is_store,
    tag:      lsu_qtag_i,
    sign_ext: lsu_qsigned_i,
    offset:   offset,
    size:     lsu_qsize_i
  };

  assign req_fire = mem.qvalid && mem.qready;
  assign rsp_fire = mem.pvalid && mem.pready;

  lsu_id_table u_id_table (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .alloc_i        (req_fire),
    .alloc_meta_i   (req_meta),
    .alloc_id_o     (req_id),
    .full_o         (table_full),
    .release_i      (rsp_fire),
    .release_id_i   (mem.pid),
    .release_meta_o (rsp_meta)
  );

  // ---------------------------------------------------------------------
  // Request formatting
  // ---------------------------------------------------------------------
  assign mem.qvalid = lsu_qvalid_i && !table_full;
  assign mem.qaddr  = {lsu_qaddr_i[31:2], 2'b00};
  assign mem.qwrite = is_store;
  assign mem.qamo   = lsu_qamo_i;
  assign mem.qid    = req_id;

  // Byte strobes
  always_comb begin
    case (lsu_qsize_i)
      SIZE_BYTE: mem.qstrb = 4'b0001 << offset;
      SIZE_HALF: mem.qstrb = 4'b0011 << offset;
      SIZE_WORD: mem.qstrb = 4'b1111;
      default:   mem.qstrb = 4'b0000;
    endcase
  end

  // Rotate store data up into its byte lanes
  always_comb begin
    case (offset)
      2'd1:    mem.qdata = {lsu_qdata_i[23:0], lsu_qdata_i[31:24]};
      2'd2:    mem.qdata = {lsu_qdata_i[15:0], lsu_qdata_i[31:16]};
      2'd3:    mem.qdata = {lsu_qdata_i[7:0], lsu_qdata_i[31:8]};
      default: mem.qdata = lsu_qdata_i;
    endcase
  end

  // Held off while the memory stalls or no ID is left
  assign lsu_qready_o = !(mem.qvalid && !mem.qready) && !table_full;

  // ---------------------------------------------------------------------
  // Response realignment
  // ---------------------------------------------------------------------
  assign shifted = mem.pdata >> {rsp_meta.offset, 3'b000};

  always_comb begin
    case (rsp_meta.size)
      SIZE_BYTE: lsu_pdata_o = {{24{shifted[7] & rsp_meta.sign_ext}}, shifted[7:0]};
      SIZE_HALF: lsu_pdata_o = {{16{shifted[15] & rsp_meta.sign_ext}}, shifted[15:0]};
      default:   lsu_pdata_o = shifted;
    endcase
  end

  assign lsu_ptag_o   = rsp_meta.tag;
  assign lsu_perror_o = mem.perror;

  // Write replies are swallowed here
  assign lsu_pvalid_o = mem.pvalid && !rsp_meta.write;
  assign mem.pready   = lsu_pready_i || rsp_meta.write;

  // ---------------------------------------------------------------------
  // Assertions
  // ---------------------------------------------------------------------
  a_req_stable: assert property (
    @(posedge clk_i) disable iff (rst_i)
    lsu_qvalid_i && !lsu_qready_o |=> lsu_qvalid_i &&
      $stable({lsu_qtag_i, lsu_qwrite_i, lsu_qsigned_i, lsu_qaddr_i,
               lsu_qdata_i, lsu_qsize_i, lsu_qamo_i}))
    else $error("Core request changed while held");

endmodule

`default_nettype wire

// File: logic/lsu_id_table.sv
// Transaction ID table
`default_nettype none

module lsu_id_table (
  input  logic                clk_i,
  input  logic                rst_i,
  // Allocate
  input  logic                alloc_i,
  input  lsu_pkg::lsu_meta_t  alloc_meta_i,
  output mem_pkg::id_t        alloc_id_o,
  output logic                full_o,
  // Release
  input  logic                release_i,
  input  mem_pkg::id_t        release_id_i,
  output lsu_pkg::lsu_meta_t  release_meta_o
);
  import lsu_pkg::*;
  import mem_pkg::*;

  logic [NUM_OUTSTANDING-1:0] free_q;
  lsu_meta_t                  meta_q [NUM_OUTSTANDING];

  // ---------------------------------------------------------------------
  // Lowest free ID
  // ---------------------------------------------------------------------
  always_comb begin
    alloc_id_o = '0;
    for (int i = NUM_OUTSTANDING - 1; i >= 0; i--) begin
      if (free_q[i]) begin
        alloc_id_o = ID_W'(i);
      end
    end
  end

  assign full_o = ~|free_q;

  // Metadata of the ID being answered
  assign release_meta_o = meta_q[release_id_i];

  // ---------------------------------------------------------------------
  // State
  // ---------------------------------------------------------------------
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      free_q <= '1;
    end else begin
      if (release_i) begin
        free_q[release_id_i] <= 1'b1;
      end
      // The released ID was busy and cannot be the allocated one
      if (alloc_i) begin
        free_q[alloc_id_o] <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (alloc_i) begin
      meta_q[alloc_id_o] <= alloc_meta_i;
    end
  end

  // ---------------------------------------------------------------------
  // Assertions
  // ---------------------------------------------------------------------
  a_alloc_free: assert property (
    @(posedge clk_i) disable iff (rst_i) alloc_i |-> free_q[alloc_id_o])
    else $error("Allocation onto busy ID %0d", alloc_id_o);

  a_release_busy: assert property (
    @(posedge clk_i) disable iff (rst_i) release_i |-> !free_q[release_id_i])
    else $error("Release of free ID %0d", release_id_i);

endmodule

`default_nettype wire

// File: logic/lsu_pkg.sv
// Load/store unit core-side types
`default_nettype none

package lsu_pkg;

  // Number of transaction IDs that may be in flight
  localparam int unsigned NUM_OUTSTANDING = 4;

  // ---------------------------------------------------------------------
  // Request encodings
  // ---------------------------------------------------------------------

  typedef enum logic [1:0] {
    SIZE_BYTE = 2'd0,
    SIZE_HALF = 2'd1,
    SIZE_WORD = 2'd2
  } size_e;

  // AMO_NONE marks a plain load or store
  typedef enum logic [3:0] {
    AMO_NONE = 4'd0,
    AMO_SWAP = 4'd1,
    AMO_ADD  = 4'd2,
    AMO_AND  = 4'd3,
    AMO_OR   = 4'd4
  } amo_e;

  typedef logic [4:0] tag_t;

  // Per-transaction record kept until the response returns
  typedef struct packed {
    logic       write;
    tag_t       tag;
    logic       sign_ext;
    logic [1:0] offset;
    size_e      size;
  } lsu_meta_t;

endpackage

`default_nettype wire

// File: logic/lsu_top.sv
// Load/store unit with memory
`default_nettype none

module lsu_top (
  input  logic              clk_i,
  input  logic              rst_i,
  // Core request
  input  lsu_pkg::tag_t     lsu_qtag_i,
  input  logic              lsu_qwrite_i,
  input  logic              lsu_qsigned_i,
  input  logic [31:0]       lsu_qaddr_i,
  input  logic [31:0]       lsu_qdata_i,
  input  lsu_pkg::size_e    lsu_qsize_i,
  input  lsu_pkg::amo_e     lsu_qamo_i,
  input  logic              lsu_qvalid_i,
  output logic              lsu_qready_o,
  // Core response
  output logic [31:0]       lsu_pdata_o,
  output lsu_pkg::tag_t     lsu_ptag_o,
  output logic              lsu_perror_o,
  output logic              lsu_pvalid_o,
  input  logic              lsu_pready_i
);

  mem_bus_if u_bus ();

  lsu u_lsu (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .lsu_qtag_i    (lsu_qtag_i),
    .lsu_qwrite_i  (lsu_qwrite_i),
    .lsu_qsigned_i (lsu_qsigned_i),
    .lsu_qaddr_i   (lsu_qaddr_i),
    .lsu_qdata_i   (lsu_qdata_i),
    .lsu_qsize_i   (lsu_qsize_i),
    .lsu_qamo_i    (lsu_qamo_i),
    .lsu_qvalid_i  (lsu_qvalid_i),
    .lsu_qready_o  (lsu_qready_o),
    .lsu_pdata_o   (lsu_pdata_o),
    .lsu_ptag_o    (lsu_ptag_o),
    .lsu_perror_o  (lsu_perror_o),
    .lsu_pvalid_o  (lsu_pvalid_o),
    .lsu_pready_i  (lsu_pready_i),
    .mem           (u_bus.lsu_mp)
  );

  ooo_mem u_mem (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .mem   (u_bus.mem_mp)
  );

endmodule

`default_nettype wire

// File: logic/mem_bus_if.sv
// Memory request and response bus
`default_nettype none

interface mem_bus_if;
  import lsu_pkg::*;
  import mem_pkg::*;

  // ---------------------------------------------------------------------
  // Request channel
  // ---------------------------------------------------------------------
  logic [31:0] qaddr;
  logic        qwrite;
  amo_e        qamo;
  logic [31:0] qdata;
  logic [3:0]  qstrb;
  id_t         qid;
  logic        qvalid;
  logic        qready;

  // ---------------------------------------------------------------------
  // Response channel
  // ---------------------------------------------------------------------
  logic [31:0] pdata;
  logic        perror;
  id_t         pid;
  logic        pvalid;
  logic        pready;

  // Load/store unit side
  modport lsu_mp (
    output qaddr, qwrite, qamo, qdata, qstrb, qid, qvalid, pready,
    input  qready, pdata, perror, pid, pvalid
  );

  // Memory side
  modport mem_mp (
    input  qaddr, qwrite, qamo, qdata, qstrb, qid, qvalid, pready,
    output qready, pdata, perror, pid, pvalid
  );

endinterface

`default_nettype wire

// File: logic/mem_pkg.sv
// Memory-side constants and types
`default_nettype none

package mem_pkg;

  // Transaction ID width for four IDs in flight
  localparam int unsigned ID_W = 2;

  // Word storage
  localparam int unsigned MEM_WORDS = 64;
  localparam int unsigned ADDR_W    = $clog2(MEM_WORDS);

  // Latency countdown wide enough for 1 + 7 cycles
  localparam int unsigned CNT_W = 4;

  typedef logic [ID_W-1:0] id_t;

  // One outstanding memory request
  typedef struct packed {
    logic             valid;
    id_t              id;
    logic [31:0]      rdata;
    logic             write;
    logic [CNT_W-1:0] count;
  } pend_t;

endpackage

`default_nettype wire

// File: logic/ooo_mem.sv
// Out-of-order word memory
`default_nettype none

module ooo_mem (
  input  logic      clk_i,
  input  logic      rst_i,
  mem_bus_if.mem_mp mem
);
  import lsu_pkg::*;
  import mem_pkg::*;

  logic [31:0]                mem_q [MEM_WORDS];
  pend_t                      pend_q [NUM_OUTSTANDING];
  logic [NUM_OUTSTANDING-1:0] ready_vec;
  logic [ID_W-1:0]            free_idx;
  logic [ID_W-1:0]            sel_idx;
  logic [ADDR_W-1:0]          widx;
  logic [31:0]                old_word;
  logic [31:0]                amo_word;
  logic [31:0]                wr_word;
  logic [31:0]                bit_mask;
  logic                       has_free;
  logic                       id_pending;
  logic                       accept;
  logic                       do_write;
  logic                       stall;

  // ---------------------------------------------------------------------
  // Pending buffer search
  // ---------------------------------------------------------------------
  always_comb begin
    has_free   = 1'b0;
    free_idx   = '0;
    sel_idx    = '0;
    id_pending = 1'b0;
    for (int i = NUM_OUTSTANDING - 1; i >= 0; i--) begin
      ready_vec[i] = pend_q[i].valid && (pend_q[i].count == '0);
      if (!pend_q[i].valid) begin
        has_free = 1'b1;
        free_idx = ID_W'(i);
      end
      if (ready_vec[i]) begin
        sel_idx = ID_W'(i);
      end
      if (pend_q[i].valid && (pend_q[i].id == mem.qid)) begin
        id_pending = 1'b1;
      end
    end
  end

  assign mem.qready = has_free;
  assign accept     = mem.qvalid && has_free;

  // ---------------------------------------------------------------------
  // Data path
  // ---------------------------------------------------------------------
  assign widx     = mem.qaddr[2 +: ADDR_W];
  assign old_word = mem_q[widx];

  always_comb begin
    for (int b = 0; b < 4; b++) begin
      bit_mask[8*b +: 8] = {8{mem.qstrb[b]}};
    end
  end

  always_comb begin
    case (mem.qamo)
      AMO_SWAP: amo_word = mem.qdata;
      AMO_ADD:  amo_word = old_word + mem.qdata;
      AMO_AND:  amo_word = old_word & mem.qdata;
      AMO_OR:   amo_word = old_word | mem.qdata;
      default:  amo_word = old_word;
    endcase
  end

  assign wr_word  = (mem.qamo == AMO_NONE) ? mem.qdata : amo_word;
  assign do_write = accept && (mem.qwrite || (mem.qamo != AMO_NONE));

  // ---------------------------------------------------------------------
  // Response
  // ---------------------------------------------------------------------
  assign mem.pvalid = |ready_vec;
  assign mem.pid    = pend_q[sel_idx].id;
  assign mem.pdata  = pend_q[sel_idx].write ? 32'h0 : pend_q[sel_idx].rdata;
  assign mem.perror = 1'b0;

  // Countdowns freeze so the presented entry stays lowest ready
  assign stall = mem.pvalid && !mem.pready;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      for (int i = 0; i < MEM_WORDS; i++) begin
        mem_q[i] <= '0;
      end
      for (int i = 0; i < NUM_OUTSTANDING; i++) begin
        pend_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < NUM_OUTSTANDING; i++) begin
        if (pend_q[i].valid && (pend_q[i].count != '0) && !stall) begin
          pend_q[i].count <= pend_q[i].count - 1'b1;
        end
      end
      if (mem.pvalid && mem.pready) begin
        pend_q[sel_idx].valid <= 1'b0;
      end
      // Latency grows with the word address
      if (accept) begin
        pend_q[free_idx] <= '{
          valid: 1'b1,
          id:    mem.qid,
          rdata: old_word,
          write: mem.qwrite && (mem.qamo == AMO_NONE),
          count: CNT_W'(mem.qaddr[4:2]) + CNT_W'(1)
        };
      end
      if (do_write) begin
        mem_q[widx] <= (old_word & ~bit_mask) | (wr_word & bit_mask);
      end
    end
  end

  // ---------------------------------------------------------------------
  // Assertions
  // ---------------------------------------------------------------------
  a_pvalid_hold: assert property (
    @(posedge clk_i) disable iff (rst_i)
    mem.pvalid && !mem.pready |=> mem.pvalid && $stable(mem.pid) && $stable(mem.pdata))
    else $error("Memory response changed under back-pressure");

  a_id_unique: assert property (
    @(posedge clk_i) disable iff (rst_i) accept |-> !id_pending)
    else $error("Accepted ID %0d is already pending", mem.qid);

endmodule

`default_nettype wire

// File: tb.f
+incdir+verification
logic/lsu_pkg.sv
logic/mem_pkg.sv
logic/mem_bus_if.sv
logic/lsu_id_table.sv
logic/lsu.sv
logic/ooo_mem.sv
logic/lsu_top.sv
verification/tb_lsu_top.sv

// File: verification/tb_lsu_model.svh
// Reference model and stimulus helpers
`ifndef TB_LSU_MODEL_SVH
`define TB_LSU_MODEL_SVH

logic [31:0] ref_mem [64];
logic [31:0] exp_data [32];
logic        pending [32];
int          loads_out;
logic [31:0] lcg_state;
tag_t        next_tag;
// 0 ready high, 1 ready low, 2 random stretches
int unsigned pready_mode;

function automatic logic [31:0] lcg_next();
  lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
  return lcg_state;
endfunction

// Lane select and extension of a load result
function automatic logic [31:0] extend_load(logic [31:0] word, logic [1:0] off,
                                            size_e size, logic sgn);
  logic [31:0] lane;
  lane = word >> (8 * off);
  case (size)
    SIZE_BYTE: return sgn ? 32'($signed(lane[7:0])) : 32'(lane[7:0]);
    SIZE_HALF: return sgn ? 32'($signed(lane[15:0])) : 32'(lane[15:0]);
    default:   return word;
  endcase
endfunction

// Applied in issue order, which is the order the memory accepts
function automatic void apply_request(tag_t tag, logic wr, logic sgn, logic [31:0] addr,
                                      logic [31:0] data, size_e size, amo_e amo);
  int unsigned w;
  int unsigned nbytes;
  logic [31:0] old;
  w      = addr[7:2];
  old    = ref_mem[w];
  nbytes = (size == SIZE_BYTE) ? 1 : (size == SIZE_HALF) ? 2 : 4;
  if (amo != AMO_NONE || !wr) begin
    exp_data[tag] = (amo != AMO_NONE) ? old : extend_load(old, addr[1:0], size, sgn);
    pending[tag]  = 1'b1;
    loads_out++;
  end
  case (amo)
    AMO_SWAP: ref_mem[w] = data;
    AMO_ADD:  ref_mem[w] = old + data;
    AMO_AND:  ref_mem[w] = old & data;
    AMO_OR:   ref_mem[w] = old | data;
    default: begin
      for (int b = 0; b < nbytes; b++) begin
        if (wr) begin
          ref_mem[w][8 * (addr[1:0] + b) +: 8] = data[8 * b +: 8];
        end
      end
    end
  endcase
endfunction

function automatic void step_pready();
  case (pready_mode)
    0:       lsu_pready_i = 1'b1;
    1:       lsu_pready_i = 1'b0;
    default: if (lcg_next() % 3 == 0) lsu_pready_i = ~lsu_pready_i;
  endcase
endfunction

task automatic issue_request(logic wr, logic sgn, logic [31:0] addr, logic [31:0] data,
                             size_e size, amo_e amo);
  int unsigned cnt;
  logic        accepted;
  @(negedge clk_i);
  step_pready();
  lsu_qtag_i    = next_tag;
  lsu_qwrite_i  = wr;
  lsu_qsigned_i = sgn;
  lsu_qaddr_i   = addr;
  lsu_qdata_i   = data;
  lsu_qsize_i   = size;
  lsu_qamo_i    = amo;
  lsu_qvalid_i  = 1'b1;
  next_tag++;
  cnt      = 0;
  accepted = 1'b0;
  while (!accepted && cnt < TIMEOUT) begin
    @(posedge clk_i);
    accepted = lsu_qready_o;
    cnt++;
    if (!accepted) begin
      @(negedge clk_i);
      step_pready();
    end
  end
  if (!accepted) begin
    timeouts++;
    $display("Request with tag %0d was never accepted in %s", lsu_qtag_i, test_name);
    report_and_finish();
  end
endtask

task automatic idle_cycles(int unsigned n);
  repeat (n) begin
    @(negedge clk_i);
    lsu_qvalid_i = 1'b0;
    step_pready();
  end
endtask

// Every open load must come back
task automatic drain_loads();
  int unsigned cnt;
  cnt         = 0;
  pready_mode = 0;
  do begin
    @(negedge clk_i);
    lsu_qvalid_i = 1'b0;
    step_pready();
    cnt++;
  end while (loads_out != 0 && cnt < TIMEOUT);
  if (loads_out != 0) begin
    timeouts++;
    $display("%0d load responses never arrived in %s", loads_out, test_name);
    report_and_finish();
  end
endtask

`endif

// File: verification/tb_lsu_top.sv
// Load/store unit testbench
`default_nettype none

module tb_lsu_top;
  timeunit 1ns;
  timeprecision 1ps;
  import lsu_pkg::*;

  localparam int unsigned TIMEOUT  = 200;
  localparam logic [31:0] LCG_SEED = 32'h5a6bbe62;

  logic        clk_i = 1'b0;
  logic        rst_i;
  tag_t        lsu_qtag_i;
  logic        lsu_qwrite_i;
  logic        lsu_qsigned_i;
  logic [31:0] lsu_qaddr_i;
  logic [31:0] lsu_qdata_i;
  size_e       lsu_qsize_i;
  amo_e        lsu_qamo_i;
  logic        lsu_qvalid_i;
  logic        lsu_qready_o;
  logic [31:0] lsu_pdata_o;
  tag_t        lsu_ptag_o;
  logic        lsu_perror_o;
  logic        lsu_pvalid_o;
  logic        lsu_pready_i;
  string       test_name = "reset";
  int unsigned errors;
  int unsigned timeouts;
  int unsigned rsp_count;

  `include "tb_lsu_model.svh"

  lsu_top u_lsu_top (.*);

  always #2 clk_i = ~clk_i;

  // ----------------------------------------------------------------------
  // Handshake monitor and checks
  // ----------------------------------------------------------------------
  always @(posedge clk_i) begin
    if (!rst_i) begin
      if (lsu_pvalid_o && lsu_pready_i) begin
        pending[lsu_ptag_o] = 1'b0;
        loads_out--;
        rsp_count++;
      end
      if (lsu_qvalid_i && lsu_qready_o) begin
        apply_request(lsu_qtag_i, lsu_qwrite_i, lsu_qsigned_i, lsu_qaddr_i,
                      lsu_qdata_i, lsu_qsize_i, lsu_qamo_i);
      end
    end
  end

  a_rsp_data: assert property (@(posedge clk_i) disable iff (rst_i)
    lsu_pvalid_o && lsu_pready_i |-> lsu_pdata_o == exp_data[lsu_ptag_o])
    else begin
      errors++;
      $display("[FAIL] %s tag %0d expected %h actual %h", test_name, $sampled(lsu_ptag_o),
               $sampled(exp_data[lsu_ptag_o]), $sampled(lsu_pdata_o));
    end

  // Catches repeated responses and responses to stores
  a_rsp_known: assert property (@(posedge clk_i) disable iff (rst_i)
    lsu_pvalid_o |-> pending[lsu_ptag_o])
    else begin
      errors++;
      $display("Response for tag %0d has no open load in %s", $sampled(lsu_ptag_o),
               test_name);
    end

  a_rsp_error: assert property (@(posedge clk_i) disable iff (rst_i)
    lsu_pvalid_o |-> !lsu_perror_o)
    else begin
      errors++;
      $display("Error flag raised on a response in %s", test_name);
    end

  a_full_stall: assert property (@(posedge clk_i) disable iff (rst_i)
    loads_out == 4 |-> !lsu_qready_o)
    else begin
      errors++;
      $display("Request ready stayed high with four loads open in %s", test_name);
    end

  task automatic report_and_finish();
    $display("Responses %0d, errors %0d, timeouts %0d", rsp_count, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  endtask

  // ----------------------------------------------------------------------
  // Stimulus
  // ----------------------------------------------------------------------
  initial begin
    logic [31:0] addr;
    logic [31:0] data;
    size_e       size;
    for (int i = 0; i < 64; i++) begin
      ref_mem[i] = '0;
    end
    for (int i = 0; i < 32; i++) begin
      exp_data[i] = '0;
      pending[i]  = 1'b0;
    end
    lcg_state     = LCG_SEED;
    loads_out     = 0;
    next_tag      = '0;
    pready_mode   = 0;
    errors        = 0;
    timeouts      = 0;
    rsp_count     = 0;
    lsu_qtag_i    = '0;
    lsu_qwrite_i  = 1'b0;
    lsu_qsigned_i = 1'b0;
    lsu_qaddr_i   = '0;
    lsu_qdata_i   = '0;
    lsu_qsize_i   = SIZE_WORD;
    lsu_qamo_i    = AMO_NONE;
    lsu_qvalid_i  = 1'b0;
    lsu_pready_i  = 1'b1;
    rst_i         = 1'b1;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;

    test_name = "word_store_load";
    addr = lcg_next() & 32'hfc;
    issue_request(1'b1, 1'b0, addr, lcg_next(), SIZE_WORD, AMO_NONE);
    issue_request(1'b0, 1'b0, addr, '0, SIZE_WORD, AMO_NONE);
    drain_loads();

    // First word has negative and positive bytes and halves
    test_name = "subword_load";
    for (int k = 0; k < 2; k++) begin
      addr = lcg_next() & 32'hfc;
      data = (k == 0) ? 32'h7f80_fe01 : lcg_next();
      issue_request(1'b1, 1'b0, addr, data, SIZE_WORD, AMO_NONE);
      for (int off = 0; off < 4; off++) begin
        issue_request(1'b0, 1'b0, addr + off, '0, SIZE_BYTE, AMO_NONE);
        issue_request(1'b0, 1'b1, addr + off, '0, SIZE_BYTE, AMO_NONE);
      end
      for (int off = 0; off < 4; off += 2) begin
        issue_request(1'b0, 1'b0, addr + off, '0, SIZE_HALF, AMO_NONE);
        issue_request(1'b0, 1'b1, addr + off, '0, SIZE_HALF, AMO_NONE);
      end
    end
    drain_loads();

    test_name = "subword_store";
    for (int k = 0; k < 8; k++) begin
      size = (lcg_next() % 2 == 0) ? SIZE_BYTE : SIZE_HALF;
      addr = lcg_next() & ((size == SIZE_HALF) ? 32'hfe : 32'hff);
      issue_request(1'b1, 1'b0, addr, lcg_next(), size, AMO_NONE);
      issue_request(1'b0, 1'b0, addr & 32'hfc, '0, SIZE_WORD, AMO_NONE);
    end
    drain_loads();

    test_name = "amo";
    for (int k = 0; k < 8; k++) begin
      addr = lcg_next() & 32'hfc;
      issue_request(1'b1, 1'b0, addr, lcg_next(), SIZE_WORD, amo_e'(k % 4 + 1));
      issue_request(1'b0, 1'b0, addr, '0, SIZE_WORD, AMO_NONE);
    end
    drain_loads();

    // Long and short latencies alternate so later loads overtake
    test_name = "out_of_order";
    for (int k = 0; k < 8; k++) begin
      addr = (k % 2 == 0) ? (7 - k / 2) * 4 : (k / 2) * 4;
      issue_request(1'b0, 1'b0, addr, '0, SIZE_WORD, AMO_NONE);
    end
    drain_loads();

    test_name = "back_pressure";
    idle_cycles(10);
    pready_mode = 1;
    for (int k = 0; k < 4; k++) begin
      issue_request(1'b0, 1'b1, lcg_next() & 32'hfc, '0, SIZE_WORD, AMO_NONE);
    end
    idle_cycles(4);
    pready_mode = 2;
    for (int k = 0; k < 32; k++) begin
      data = lcg_next();
      size = size_e'(data[1:0] % 3);
      addr = lcg_next() & ((size == SIZE_WORD) ? 32'hfc :
                           (size == SIZE_HALF) ? 32'hfe : 32'hff);
      issue_request(data[2], data[3], addr, lcg_next(), size, AMO_NONE);
    end
    drain_loads();
    report_and_finish();
  end

endmodule

`default_nettype wire
